//--- rtl/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// datapath width
`define EXU_XLEN 32

// gpr index width
`define EXU_REG_AW 5

// radix-4 booth, two multiplier bits per step
`define EXU_MUL_STEPS 16

// restoring divider, one quotient bit per step
`define EXU_DIV_STEPS 32

`endif

//--- rtl/exu_pkg.sv
`default_nettype none

`include "exu_defines.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0]   word_t;
  typedef logic [2*`EXU_XLEN-1:0] dword_t;
  typedef logic [`EXU_REG_AW-1:0] reg_addr_t;

  // funct3 of the integer ops, reused for the M extension kinds
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_srl  = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_funct_t;

  typedef enum logic [2:0] {
    goto_none = 3'b000,
    goto_jal  = 3'b001,
    goto_jalr = 3'b010,
    goto_jreg = 3'b011,
    goto_bnz  = 3'b100,
    goto_bz   = 3'b101
  } goto_t;

  // operand signedness, a first
  typedef enum logic [1:0] {
    mul_ss = 2'b00,
    mul_su = 2'b01,
    mul_uu = 2'b10
  } mul_sign_t;

  typedef enum logic [1:0] {
    unit_alu  = 2'b00,
    unit_mul  = 2'b01,
    unit_div  = 2'b10,
    unit_pass = 2'b11
  } unit_t;

  typedef enum logic [1:0] {
    mul_st_idle = 2'b00,
    mul_st_run  = 2'b01,
    mul_st_done = 2'b10
  } mul_state_t;

  typedef enum logic [1:0] {
    div_st_idle = 2'b00,
    div_st_run  = 2'b01,
    div_st_done = 2'b10
  } div_state_t;

endpackage

`default_nettype wire

//--- rtl/exu_issue_reg.sv
`default_nettype none

module exu_issue_reg import exu_pkg::*; (
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       in_valid,
  output logic            in_ready,
  input  wire word_t      in_pc,
  input  wire word_t      in_val_a,
  input  wire word_t      in_val_b,
  input  wire word_t      in_val_c,
  input  wire logic       in_alu_src,
  input  wire alu_funct_t in_alu_funct,
  input  wire logic       in_alu_sw,
  input  wire logic       in_mul,
  input  wire reg_addr_t  in_rd,
  input  wire logic       in_rd_src,
  input  wire goto_t      in_goto,
  input  wire logic       retire,
  output logic            valid,
  output word_t           pc,
  output word_t           val_a,
  output word_t           val_c,
  output word_t           op_a,
  output word_t           op_b,
  output alu_funct_t      alu_funct,
  output logic            alu_sw,
  output unit_t           unit,
  output reg_addr_t       rd,
  output goto_t           goto,
  output logic            mul_start,
  output logic            div_start,
  output mul_sign_t       mul_sign,
  output logic            div_signed
);

  logic      accept;
  logic      alu_src;
  word_t     val_b;
  unit_t     in_unit;
  mul_sign_t in_mul_sign;

  // single entry, refilled in the cycle it drains
  assign in_ready = !valid || retire;
  assign accept   = in_valid && in_ready;

  always_comb begin
    if (in_mul) begin
      in_unit = in_alu_funct[2] ? unit_div : unit_mul;
    end else begin
      in_unit = in_rd_src ? unit_pass : unit_alu;
    end
    // mul and mulh both signed, low word does not care
    case (in_alu_funct[1:0])
      2'b10:   in_mul_sign = mul_su;
      2'b11:   in_mul_sign = mul_uu;
      default: in_mul_sign = mul_ss;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid     <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end else begin
      mul_start <= accept && in_mul && !in_alu_funct[2];
      div_start <= accept && in_mul && in_alu_funct[2];
      if (accept) begin
        valid <= 1'b1;
      end else if (retire) begin
        valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pc         <= in_pc;
      val_a      <= in_val_a;
      val_b      <= in_val_b;
      val_c      <= in_val_c;
      alu_src    <= in_alu_src;
      alu_funct  <= in_alu_funct;
      alu_sw     <= in_alu_sw;
      unit       <= in_unit;
      rd         <= in_rd;
      goto       <= in_goto;
      mul_sign   <= in_mul_sign;
      div_signed <= !in_alu_funct[0];
    end
  end

  // pc-relative ops take pc as the first operand
  assign op_a = alu_src ? pc : val_a;
  assign op_b = val_b;

  // a retire only ever drains a held entry
  a_retire_held: assert property (@(posedge clock) disable iff (reset)
    retire |-> valid);

endmodule

`default_nettype wire

//--- rtl/exu_alu.sv
`default_nettype none

`include "exu_defines.svh"

module exu_alu import exu_pkg::*; (
  input  wire word_t      a,
  input  wire word_t      b,
  input  wire alu_funct_t funct,
  input  wire logic       sw,
  output word_t           val
);

  localparam int SHW = $clog2(`EXU_XLEN);

  logic [SHW-1:0] shamt;

  assign shamt = b[SHW-1:0];

  // sw turns add into sub and srl into sra
  always_comb begin
    case (funct)
      alu_add: begin
        val = sw ? (a - b) : (a + b);
      end
      alu_sll: begin
        val = a << shamt;
      end
      alu_slt: begin
        val = word_t'($signed(a) < $signed(b));
      end
      alu_sltu: begin
        val = word_t'(a < b);
      end
      alu_xor: begin
        val = a ^ b;
      end
      alu_srl: begin
        val = sw ? word_t'($signed(a) >>> shamt) : (a >> shamt);
      end
      alu_or: begin
        val = a | b;
      end
      alu_and: begin
        val = a & b;
      end
      default: begin
        val = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/exu_mul.sv
`default_nettype none

`include "exu_defines.svh"

module exu_mul import exu_pkg::*; (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      start,
  input  wire mul_sign_t sign,
  input  wire word_t     a,
  input  wire word_t     b,
  output logic           done,
  output dword_t         prod
);

  localparam int W  = `EXU_XLEN;
  localparam int CW = $clog2(`EXU_MUL_STEPS);

  mul_state_t    state;
  logic [CW-1:0] cnt;
  dword_t        mcand;
  dword_t        acc;
  logic [W:0]    mplr;
  dword_t        pp;
  dword_t        a_ext;
  logic          a_signed;
  logic          b_signed;

  assign a_signed = (sign != mul_uu);
  assign b_signed = (sign == mul_ss);
  assign a_ext    = {{W{a_signed & a[W-1]}}, a};

  // booth digit from the current three-bit window
  always_comb begin
    case (mplr[2:0])
      3'b001, 3'b010: pp = mcand;
      3'b011:         pp = mcand << 1;
      3'b100:         pp = -(mcand << 1);
      3'b101, 3'b110: pp = -mcand;
      default:        pp = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= mul_st_idle;
      cnt   <= '0;
    end else if (start) begin
      state <= mul_st_run;
      cnt   <= '0;
    end else if (state == mul_st_run) begin
      cnt <= cnt + 1'b1;
      if (cnt == CW'(`EXU_MUL_STEPS - 1)) begin
        state <= mul_st_done;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      mcand <= a_ext;
      mplr  <= {b, 1'b0};
      // recoding reads b as signed, an unsigned b with msb set needs a << W on top
      acc   <= (!b_signed && b[W-1]) ? (a_ext << W) : '0;
    end else if (state == mul_st_run) begin
      acc   <= acc + pp;
      mcand <= mcand << 2;
      mplr  <= mplr >> 2;
    end
  end

  // a new start hides the previous completion
  assign done = (state == mul_st_done) && !start;
  assign prod = acc;

  a_no_restart: assert property (@(posedge clock) disable iff (reset)
    start |-> (state != mul_st_run));

endmodule

`default_nettype wire

//--- rtl/exu_div.sv
`default_nettype none

`include "exu_defines.svh"

module exu_div import exu_pkg::*; (
  input  wire logic  clock,
  input  wire logic  reset,
  input  wire logic  start,
  input  wire logic  signed_op,
  input  wire word_t a,
  input  wire word_t b,
  output logic       done,
  output word_t      quot,
  output word_t      rem
);

  localparam int W  = `EXU_XLEN;
  localparam int CW = $clog2(`EXU_DIV_STEPS);

  div_state_t    state;
  logic [CW-1:0] cnt;
  word_t         q;
  word_t         r;
  word_t         d;
  logic          q_neg;
  logic          r_neg;
  logic          a_neg;
  logic          b_neg;
  word_t         a_mag;
  word_t         b_mag;
  logic [W:0]    sh;
  logic [W:0]    diff;

  assign a_neg = signed_op & a[W-1];
  assign b_neg = signed_op & b[W-1];
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  // partial remainder with the next dividend bit shifted in
  assign sh   = {r, q[W-1]};
  assign diff = sh - {1'b0, d};

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= div_st_idle;
      cnt   <= '0;
    end else if (start) begin
      state <= div_st_run;
      cnt   <= '0;
    end else if (state == div_st_run) begin
      cnt <= cnt + 1'b1;
      if (cnt == CW'(`EXU_DIV_STEPS - 1)) begin
        state <= div_st_done;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      q     <= a_mag;
      r     <= '0;
      d     <= b_mag;
      // x/0 keeps the all-ones quotient, so no negation there
      q_neg <= (a_neg ^ b_neg) && (b != '0);
      r_neg <= a_neg;
    end else if (state == div_st_run) begin
      if (sh >= {1'b0, d}) begin
        r <= diff[W-1:0];
        q <= {q[W-2:0], 1'b1};
      end else begin
        r <= sh[W-1:0];
        q <= {q[W-2:0], 1'b0};
      end
    end
  end

  // most-negative / -1 falls out as the dividend with rem 0
  assign quot = q_neg ? -q : q;
  assign rem  = r_neg ? -r : r;
  assign done = (state == div_st_done) && !start;

  a_rem_range: assert property (@(posedge clock) disable iff (reset)
    (done && (d != '0)) |-> (r < d));

endmodule

`default_nettype wire

//--- rtl/exu_branch.sv
`default_nettype none

module exu_branch import exu_pkg::*; (
  input  wire logic  valid,
  input  wire goto_t goto,
  input  wire word_t pc,
  input  wire word_t val_a,
  input  wire word_t val_c,
  input  wire word_t alu_val,
  output logic       jump_flush,
  output word_t      jump_dnpc
);

  logic  taken;
  logic  predict;
  logic  alu_any;
  word_t base;
  word_t offset;
  word_t dnpc;

  assign alu_any = |alu_val;

  always_comb begin
    case (goto)
      goto_none: taken = 1'b0;
      goto_bnz:  taken = alu_any;
      goto_bz:   taken = !alu_any;
      default:   taken = 1'b1;
    endcase
  end

  // register-based targets start from val_a
  always_comb begin
    case (goto)
      goto_jalr, goto_jreg: base = val_a;
      default:              base = pc;
    endcase
    offset = (goto == goto_jreg) ? '0 : val_c;
  end

  assign dnpc = base + (taken ? offset : word_t'(4));

  // backward branches predicted taken, jumps never
  assign predict = ((goto == goto_bnz) || (goto == goto_bz)) && val_c[31];

  assign jump_flush = valid && (taken ^ predict);
  assign jump_dnpc  = {dnpc[31:1], 1'b0};

endmodule

`default_nettype wire

//--- rtl/exu_writeback.sv
`default_nettype none

`include "exu_defines.svh"

module exu_writeback import exu_pkg::*; (
  input  wire logic       valid,
  input  wire unit_t      unit,
  input  wire alu_funct_t alu_funct,
  input  wire word_t      alu_val,
  input  wire word_t      val_a,
  input  wire logic       mul_done,
  input  wire dword_t     prod,
  input  wire logic       div_done,
  input  wire word_t      quot,
  input  wire word_t      rem,
  input  wire logic       out_ready,
  output logic            out_valid,
  output word_t           out_gpr_wdata,
  output logic            retire
);

  localparam int W = `EXU_XLEN;

  logic unit_done;

  always_comb begin
    case (unit)
      unit_mul: begin
        // only mul itself wants the low word
        out_gpr_wdata = (|alu_funct[1:0]) ? prod[2*W-1:W] : prod[W-1:0];
        unit_done     = mul_done;
      end
      unit_div: begin
        out_gpr_wdata = alu_funct[1] ? rem : quot;
        unit_done     = div_done;
      end
      unit_pass: begin
        out_gpr_wdata = val_a;
        unit_done     = 1'b1;
      end
      default: begin
        out_gpr_wdata = alu_val;
        unit_done     = 1'b1;
      end
    endcase
  end

  assign out_valid = valid && unit_done;
  assign retire    = out_valid && out_ready;

endmodule

`default_nettype wire

//--- rtl/exu_top.sv
`default_nettype none

module exu_top import exu_pkg::*; (
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       in_valid,
  output logic            in_ready,
  input  wire word_t      in_pc,
  input  wire word_t      in_val_a,
  input  wire word_t      in_val_b,
  input  wire word_t      in_val_c,
  input  wire logic       in_alu_src,
  input  wire alu_funct_t in_alu_funct,
  input  wire logic       in_alu_sw,
  input  wire logic       in_mul,
  input  wire reg_addr_t  in_rd,
  input  wire logic       in_rd_src,
  input  wire goto_t      in_goto,
  input  wire logic       out_ready,
  output logic            out_valid,
  output reg_addr_t       out_gpr_waddr,
  output word_t           out_gpr_wdata,
  output word_t           out_pc,
  output logic            jump_flush,
  output word_t           jump_dnpc
);

  logic       valid;
  word_t      pc;
  word_t      val_a;
  word_t      val_c;
  word_t      op_a;
  word_t      op_b;
  alu_funct_t alu_funct;
  logic       alu_sw;
  unit_t      unit;
  goto_t      goto;
  logic       mul_start;
  logic       div_start;
  mul_sign_t  mul_sign;
  logic       div_signed;
  word_t      alu_val;
  logic       mul_done;
  dword_t     prod;
  logic       div_done;
  word_t      quot;
  word_t      rem;
  logic       retire;

  exu_issue_reg i_issue (
    .clock(clock), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready),
    .in_pc(in_pc), .in_val_a(in_val_a), .in_val_b(in_val_b), .in_val_c(in_val_c),
    .in_alu_src(in_alu_src), .in_alu_funct(in_alu_funct), .in_alu_sw(in_alu_sw),
    .in_mul(in_mul), .in_rd(in_rd), .in_rd_src(in_rd_src), .in_goto(in_goto),
    .retire(retire), .valid(valid),
    .pc(pc), .val_a(val_a), .val_c(val_c), .op_a(op_a), .op_b(op_b),
    .alu_funct(alu_funct), .alu_sw(alu_sw), .unit(unit),
    .rd(out_gpr_waddr), .goto(goto),
    .mul_start(mul_start), .div_start(div_start),
    .mul_sign(mul_sign), .div_signed(div_signed)
  );

  exu_alu i_alu (
    .a(op_a), .b(op_b), .funct(alu_funct), .sw(alu_sw), .val(alu_val)
  );

  exu_mul i_mul (
    .clock(clock), .reset(reset), .start(mul_start), .sign(mul_sign),
    .a(op_a), .b(op_b), .done(mul_done), .prod(prod)
  );

  exu_div i_div (
    .clock(clock), .reset(reset), .start(div_start), .signed_op(div_signed),
    .a(op_a), .b(op_b), .done(div_done), .quot(quot), .rem(rem)
  );

  exu_branch i_branch (
    .valid(valid), .goto(goto), .pc(pc), .val_a(val_a), .val_c(val_c),
    .alu_val(alu_val), .jump_flush(jump_flush), .jump_dnpc(jump_dnpc)
  );

  exu_writeback i_writeback (
    .valid(valid), .unit(unit), .alu_funct(alu_funct),
    .alu_val(alu_val), .val_a(val_a),
    .mul_done(mul_done), .prod(prod),
    .div_done(div_done), .quot(quot), .rem(rem),
    .out_ready(out_ready), .out_valid(out_valid),
    .out_gpr_wdata(out_gpr_wdata), .retire(retire)
  );

  assign out_pc = pc;

endmodule

`default_nettype wire

//--- test/exu_tb_table.svh
`ifndef EXU_TB_TABLE_SVH
`define EXU_TB_TABLE_SVH

// directed entries, expected values worked out by hand
task automatic fill_table();
  // alu ops: funct, sw, md, pass, a, b, expected wdata
  op_vec(3'd0, 0, 0, 0, 'h00000005, 'h00000007, 'h0000000c);
  op_vec(3'd0, 0, 0, 0, 'h7fffffff, 'h00000001, 'h80000000);
  op_vec(3'd0, 1, 0, 0, 'h00000005, 'h00000007, 'hfffffffe);
  op_vec(3'd0, 1, 0, 0, 'h00000000, 'h00000001, 'hffffffff);
  op_vec(3'd1, 0, 0, 0, 'h00000001, 'h0000001f, 'h80000000);
  op_vec(3'd1, 0, 0, 0, 'h12345678, 'h00000024, 'h23456780);
  op_vec(3'd2, 0, 0, 0, 'hffffffff, 'h00000001, 'h00000001);
  op_vec(3'd2, 0, 0, 0, 'h00000001, 'hffffffff, 'h00000000);
  op_vec(3'd3, 0, 0, 0, 'h00000001, 'hffffffff, 'h00000001);
  op_vec(3'd3, 0, 0, 0, 'hffffffff, 'h00000001, 'h00000000);
  op_vec(3'd4, 0, 0, 0, 'hff00ff00, 'h0ff00ff0, 'hf0f0f0f0);
  op_vec(3'd5, 0, 0, 0, 'h80000000, 'h00000004, 'h08000000);
  op_vec(3'd5, 1, 0, 0, 'h80000000, 'h00000004, 'hf8000000);
  op_vec(3'd5, 1, 0, 0, 'h7ffffff0, 'h00000004, 'h07ffffff);
  op_vec(3'd6, 0, 0, 0, 'hf0f00000, 'h0000f0f0, 'hf0f0f0f0);
  op_vec(3'd7, 0, 0, 0, 'hdeadbeef, 'h0000ffff, 'h0000beef);
  // val_a pass-through
  op_vec(3'd0, 0, 0, 1, 'hcafef00d, 'h12345678, 'hcafef00d);
  op_vec(3'd0, 0, 0, 1, 'h00000000, 'hffffffff, 'h00000000);
  // multiplies: mul, mulh, mulhsu, mulhu
  op_vec(3'd0, 0, 1, 0, 'h00000007, 'h00000006, 'h0000002a);
  op_vec(3'd0, 0, 1, 0, 'hffffffff, 'hffffffff, 'h00000001);
  op_vec(3'd1, 0, 1, 0, 'hffffffff, 'hffffffff, 'h00000000);
  op_vec(3'd1, 0, 1, 0, 'h80000000, 'h80000000, 'h40000000);
  op_vec(3'd1, 0, 1, 0, 'h80000000, 'h7fffffff, 'hc0000000);
  op_vec(3'd2, 0, 1, 0, 'hffffffff, 'hffffffff, 'hffffffff);
  op_vec(3'd2, 0, 1, 0, 'h00000002, 'h80000000, 'h00000001);
  op_vec(3'd3, 0, 1, 0, 'hffffffff, 'hffffffff, 'hfffffffe);
  // divides: div, divu, rem, remu
  op_vec(3'd4, 0, 1, 0, 'h00000014, 'hfffffffd, 'hfffffffa);
  op_vec(3'd6, 0, 1, 0, 'h00000014, 'hfffffffd, 'h00000002);
  op_vec(3'd4, 0, 1, 0, 'hffffffec, 'h00000003, 'hfffffffa);
  op_vec(3'd6, 0, 1, 0, 'hffffffec, 'h00000003, 'hfffffffe);
  op_vec(3'd4, 0, 1, 0, 'h00000007, 'h00000000, 'hffffffff);
  op_vec(3'd6, 0, 1, 0, 'h00000007, 'h00000000, 'h00000007);
  op_vec(3'd4, 0, 1, 0, 'hfffffff9, 'h00000000, 'hffffffff);
  op_vec(3'd6, 0, 1, 0, 'hfffffff9, 'h00000000, 'hfffffff9);
  op_vec(3'd5, 0, 1, 0, 'h80000000, 'h00000000, 'hffffffff);
  op_vec(3'd7, 0, 1, 0, 'h80000000, 'h00000000, 'h80000000);
  op_vec(3'd4, 0, 1, 0, 'h80000000, 'hffffffff, 'h80000000);
  op_vec(3'd6, 0, 1, 0, 'h80000000, 'hffffffff, 'h00000000);
  op_vec(3'd5, 0, 1, 0, 'hffffffff, 'h00000002, 'h7fffffff);
  op_vec(3'd7, 0, 1, 0, 'hffffffff, 'h00000002, 'h00000001);
  op_vec(3'd5, 0, 1, 0, 'h80000000, 'hffffffff, 'h00000000);
  op_vec(3'd7, 0, 1, 0, 'h80000000, 'hffffffff, 'h80000000);
  // kind, funct, sw, alu_src, pc, a, b, offset, wdata, flush, dnpc
  cti_vec(goto_none, 3'd0, 0, 1, 'h2000, 'h0, 'h1000, 'h0, 'h3000, 0, 'h2004);
  cti_vec(goto_none, 3'd0, 0, 1, 'h2004, 'h0, 'hfffff000, 'h0, 'h1004, 0, 'h2008);
  // beq, bne, blt, bge, bltu, bgeu both ways
  cti_vec(goto_bz, 3'd0, 1, 0, 'h100, 'h5, 'h5, 'h10, 'h0, 1, 'h110);
  cti_vec(goto_bz, 3'd0, 1, 0, 'h104, 'h5, 'h6, 'h10, 'hffffffff, 0, 'h108);
  cti_vec(goto_bnz, 3'd0, 1, 0, 'h200, 'h5, 'h6, 'hfffffff0, 'hffffffff, 0, 'h1f0);
  cti_vec(goto_bnz, 3'd0, 1, 0, 'h204, 'h9, 'h9, 'hfffffff0, 'h0, 1, 'h208);
  cti_vec(goto_bnz, 3'd2, 0, 0, 'h300, 'hfffffffe, 'h1, 'h20, 'h1, 1, 'h320);
  cti_vec(goto_bz, 3'd2, 0, 0, 'h304, 'hfffffffe, 'h1, 'hffffffe0, 'h1, 1, 'h308);
  cti_vec(goto_bnz, 3'd3, 0, 0, 'h400, 'h1, 'hffffffff, 'hffffff00, 'h1, 0, 'h300);
  cti_vec(goto_bz, 3'd3, 0, 0, 'h404, 'h1, 'h2, 'h40, 'h1, 0, 'h408);
  cti_vec(goto_bz, 3'd3, 0, 0, 'h408, 'h5, 'h2, 'hfffffff8, 'h0, 0, 'h400);
  // jumps link pc + 4 and are never predicted
  cti_vec(goto_jal, 3'd0, 0, 1, 'h500, 'h0, 'h4, 'h80, 'h504, 1, 'h580);
  cti_vec(goto_jal, 3'd0, 0, 1, 'h504, 'h0, 'h4, 'hffffff00, 'h508, 1, 'h404);
  cti_vec(goto_jalr, 3'd0, 0, 1, 'h600, 'h1001, 'h4, 'h4, 'h604, 1, 'h1004);
  cti_vec(goto_jalr, 3'd0, 0, 1, 'h608, 'h2000, 'h4, 'hfffffffd, 'h60c, 1, 'h1ffc);
  cti_vec(goto_jreg, 3'd0, 0, 1, 'h700, 'h3003, 'h4, 'h10, 'h704, 1, 'h3002);
endtask

`endif

//--- test/exu_tb.sv
`default_nettype none

module exu_tb import exu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 16;
  localparam int    N_RAND       = 48;
  localparam word_t SEED         = 32'h0507655c;

  typedef struct packed {
    word_t      pc;
    word_t      val_a;
    word_t      val_b;
    word_t      val_c;
    logic       alu_src;
    alu_funct_t funct;
    logic       sw;
    logic       md;
    logic       pass;
    goto_t      kind;
    reg_addr_t  rd;
    word_t      exp_wdata;
    logic       exp_flush;
    word_t      exp_dnpc;
  } vec_t;

  logic       clock;
  logic       reset;
  logic       in_valid;
  logic       in_ready;
  word_t      in_pc;
  word_t      in_val_a;
  word_t      in_val_b;
  word_t      in_val_c;
  logic       in_alu_src;
  alu_funct_t in_alu_funct;
  logic       in_alu_sw;
  logic       in_mul;
  reg_addr_t  in_rd;
  logic       in_rd_src;
  goto_t      in_goto;
  logic       out_ready;
  logic       out_valid;
  reg_addr_t  out_gpr_waddr;
  word_t      out_gpr_wdata;
  word_t      out_pc;
  logic       jump_flush;
  word_t      jump_dnpc;

  vec_t      vecs[$];
  vec_t      pending[$];
  vec_t      head;
  word_t     table_pc = 'h1000;
  word_t     rng = SEED;
  word_t     bp_state = SEED;
  logic      bp_en = 1'b0;
  int        issued = 0;
  int        err_count = 0;
  int        check_count = 0;
  int        base_errs = 0;
  int        base_checks = 0;
  int        n_tests = 0;
  logic      stalled = 1'b0;
  reg_addr_t snap_rd;
  word_t     snap_wdata;
  word_t     snap_pc;
  logic      snap_flush;
  word_t     snap_dnpc;

  exu_top i_dut (
    .clock(clock), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready),
    .in_pc(in_pc), .in_val_a(in_val_a), .in_val_b(in_val_b), .in_val_c(in_val_c),
    .in_alu_src(in_alu_src), .in_alu_funct(in_alu_funct), .in_alu_sw(in_alu_sw),
    .in_mul(in_mul), .in_rd(in_rd), .in_rd_src(in_rd_src), .in_goto(in_goto),
    .out_ready(out_ready), .out_valid(out_valid),
    .out_gpr_waddr(out_gpr_waddr), .out_gpr_wdata(out_gpr_wdata), .out_pc(out_pc),
    .jump_flush(jump_flush), .jump_dnpc(jump_dnpc)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  function automatic word_t lcg_next(input word_t s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
  endfunction

  // mostly raw values, now and then a corner value or a small one
  function automatic word_t pick_operand(input word_t s);
    if (s[31:29] == 3'b000) begin
      case (s[1:0])
        2'd0:    pick_operand = 32'h00000000;
        2'd1:    pick_operand = 32'h00000001;
        2'd2:    pick_operand = 32'hffffffff;
        default: pick_operand = 32'h80000000;
      endcase
    end else if (s[28:27] == 2'b00) begin
      pick_operand = s >> s[4:0];
    end else begin
      pick_operand = s;
    end
  endfunction

  // RV32M result from the ISA rules
  function automatic word_t muldiv_ref(input logic [2:0] f, input word_t a, input word_t b);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] p;
    word_t       q;
    word_t       r;
    ax = {{32{a[31] && (f != 3'd3)}}, a};
    bx = {{32{b[31] && (f[1] == 1'b0)}}, b};
    p  = ax * bx;
    if (b == 32'h0) begin
      q = 32'hffffffff;
      r = a;
    end else if (!f[0] && (a == 32'h80000000) && (b == 32'hffffffff)) begin
      q = a;
      r = 32'h0;
    end else if (!f[0]) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    if (!f[2]) begin
      muldiv_ref = (f == 3'd0) ? p[31:0] : p[63:32];
    end else begin
      muldiv_ref = f[1] ? r : q;
    end
  endfunction

  task automatic flag_mismatch(input string msg);
    err_count++;
    $display("MISMATCH at %0t ns: %s", $time, msg);
  endtask

  task automatic op_vec(input logic [2:0] f, input logic sw, input logic md,
                        input logic pass, input word_t a, input word_t b, input word_t exp);
    vec_t v;
    v           = '0;
    v.pc        = table_pc;
    v.val_a     = a;
    v.val_b     = b;
    v.funct     = alu_funct_t'(f);
    v.sw        = sw;
    v.md        = md;
    v.pass      = pass;
    v.kind      = goto_none;
    v.exp_wdata = exp;
    v.exp_dnpc  = table_pc + 32'd4;
    vecs.push_back(v);
    table_pc += 32'd4;
  endtask

  task automatic cti_vec(input goto_t kind, input logic [2:0] f, input logic sw,
                         input logic alu_src, input word_t pc, input word_t a, input word_t b,
                         input word_t off, input word_t wdata, input logic flush,
                         input word_t dnpc);
    vec_t v;
    v           = '0;
    v.pc        = pc;
    v.val_a     = a;
    v.val_b     = b;
    v.val_c     = off;
    v.alu_src   = alu_src;
    v.funct     = alu_funct_t'(f);
    v.sw        = sw;
    v.kind      = kind;
    v.exp_wdata = wdata;
    v.exp_flush = flush;
    v.exp_dnpc  = dnpc;
    vecs.push_back(v);
  endtask

  `include "exu_tb_table.svh"

  // called on a rising edge, returns on the edge that accepts
  task automatic issue(input vec_t v);
    vec_t e;
    e            = v;
    e.rd         = reg_addr_t'(issued);
    in_valid     <= 1'b1;
    in_pc        <= e.pc;
    in_val_a     <= e.val_a;
    in_val_b     <= e.val_b;
    in_val_c     <= e.val_c;
    in_alu_src   <= e.alu_src;
    in_alu_funct <= e.funct;
    in_alu_sw    <= e.sw;
    in_mul       <= e.md;
    in_rd        <= e.rd;
    in_rd_src    <= e.pass;
    in_goto      <= e.kind;
    @(negedge clock);
    while (!in_ready) @(negedge clock);
    pending.push_back(e);
    issued++;
    @(posedge clock);
  endtask

  // after the last retire the stage must be empty again
  task automatic drain();
    while (pending.size() != 0) @(posedge clock);
    @(negedge clock);
    check_count++;
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      err_count++;
      $display("error at %0t ns: the stage is still busy after the last retire", $time);
    end
    @(posedge clock);
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %-14s checks %0d errors %0d", name,
             check_count - base_checks, err_count - base_errs);
    base_checks = check_count;
    base_errs   = err_count;
  endtask

  // random back-pressure, about one cycle in four
  always @(posedge clock) begin
    bp_state = lcg_next(bp_state);
    out_ready <= !(bp_en && (bp_state[31:30] == 2'b00));
  end

  // outputs sampled mid-cycle, a retire happens on the next rising edge
  always @(negedge clock) begin
    if (!reset) begin
      if (stalled) begin
        check_count++;
        if (!out_valid || out_gpr_waddr !== snap_rd || out_gpr_wdata !== snap_wdata ||
            out_pc !== snap_pc || jump_flush !== snap_flush || jump_dnpc !== snap_dnpc) begin
          flag_mismatch($sformatf("outputs changed while stalled, pc %h", snap_pc));
        end
      end
      stalled    = out_valid && !out_ready;
      snap_rd    = out_gpr_waddr;
      snap_wdata = out_gpr_wdata;
      snap_pc    = out_pc;
      snap_flush = jump_flush;
      snap_dnpc  = jump_dnpc;
      if (out_valid && out_ready) begin
        if (pending.size() == 0) begin
          err_count++;
          $display("error at %0t ns: a result retired with nothing outstanding", $time);
        end else begin
          head = pending.pop_front();
          check_count += 5;
          if (out_gpr_waddr !== head.rd) begin
            flag_mismatch($sformatf("pc %h rd got %0d expected %0d",
                                    head.pc, out_gpr_waddr, head.rd));
          end
          if (out_gpr_wdata !== head.exp_wdata) begin
            flag_mismatch($sformatf("pc %h wdata got %h expected %h",
                                    head.pc, out_gpr_wdata, head.exp_wdata));
          end
          if (out_pc !== head.pc) begin
            flag_mismatch($sformatf("out_pc got %h expected %h", out_pc, head.pc));
          end
          if (jump_flush !== head.exp_flush) begin
            flag_mismatch($sformatf("pc %h flush got %b expected %b",
                                    head.pc, jump_flush, head.exp_flush));
          end
          if (jump_dnpc !== head.exp_dnpc) begin
            flag_mismatch($sformatf("pc %h dnpc got %h expected %h",
                                    head.pc, jump_dnpc, head.exp_dnpc));
          end
        end
      end
    end
  end

  initial begin
    int limit;
    @(negedge reset);
    limit = (vecs.size() + N_RAND) * 40 * 2;
    #(limit * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int    i;
    vec_t  v;
    word_t a;
    word_t b;
    reset        <= 1'b1;
    in_valid     <= 1'b0;
    in_pc        <= '0;
    in_val_a     <= '0;
    in_val_b     <= '0;
    in_val_c     <= '0;
    in_alu_src   <= 1'b0;
    in_alu_funct <= alu_add;
    in_alu_sw    <= 1'b0;
    in_mul       <= 1'b0;
    in_rd        <= '0;
    in_rd_src    <= 1'b0;
    in_goto      <= goto_none;
    out_ready    <= 1'b1;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    @(negedge clock);
    check_count += 3;
    if (out_valid !== 1'b0) flag_mismatch("out_valid not low after reset");
    if (jump_flush !== 1'b0) flag_mismatch("jump_flush not low after reset");
    if (in_ready !== 1'b1) flag_mismatch("in_ready not high after reset");
    end_test("reset");

    @(posedge clock);
    for (i = 0; i < vecs.size(); i++) begin
      issue(vecs[i]);
    end
    in_valid <= 1'b0;
    drain();
    end_test("directed");

    // multiply and divide kinds on random operands, with back-pressure
    bp_en <= 1'b1;
    for (i = 0; i < N_RAND; i++) begin
      rng         = lcg_next(rng);
      v           = '0;
      v.funct     = alu_funct_t'(rng[31:29]);
      rng         = lcg_next(rng);
      a           = pick_operand(rng);
      rng         = lcg_next(rng);
      b           = pick_operand(rng);
      v.pc        = 32'h8000 + 32'(i * 4);
      v.val_a     = a;
      v.val_b     = b;
      v.md        = 1'b1;
      v.kind      = goto_none;
      v.exp_wdata = muldiv_ref(v.funct, a, b);
      v.exp_dnpc  = v.pc + 32'd4;
      issue(v);
    end
    in_valid <= 1'b0;
    drain();
    end_test("random muldiv");

    $display("tests %0d, checks %0d, errors %0d", n_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
+incdir+test
rtl/exu_pkg.sv
rtl/exu_issue_reg.sv
rtl/exu_alu.sv
rtl/exu_mul.sv
rtl/exu_div.sv
rtl/exu_branch.sv
rtl/exu_writeback.sv
rtl/exu_top.sv
test/exu_tb.sv
